/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps -Wno-fatal -j 0
TOP      = tb_fill_readout
FILELIST = tb.f
OBJ_DIR  = obj_dir
SIM      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST)) fill_defines.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) +verilator+error+limit+100

clean:
	rm -rf $(OBJ_DIR)

/* fill_ctl_pkg.sv */
// Fill readout control types
package fill_ctl_pkg;

	`include "fill_defines.svh"

	// Bit positions in the one-hot state vector
	// st_idle must stay at 0, the reset vector relies on it
	typedef enum logic [4:0] {
		st_idle, st_chk_fifo_empty, st_error, st_get_fifo_hdr,
		st_get_mem_hdr, st_compare_hdr,
		st_csn_wait, st_csn_send, st_cc_wait, st_cc_send,
		st_get_dat_burst,
		st_w0_wait, st_w0_send, st_w1_wait, st_w1_send,
		st_w2_wait, st_w2_send, st_w3_wait, st_w3_send,
		st_done
	} fill_state_e;

	// What goes on the stream in a slot
	typedef enum logic [1:0] {
		slot_serial, slot_cmd, slot_inv_cmd, slot_data
	} fill_slot_e;

	// 32-bit lane of a burst, lane 0 is bits 31..0
	typedef logic [$clog2(`FILL_WORDS_PER_BURST)-1:0] fill_lane_t;

endpackage

/* fill_defines.svh */
// Fill readout widths and counts
`ifndef FILL_DEFINES_SVH
`define FILL_DEFINES_SVH

// TX stream word
`define FILL_WORD_W 32

// DDR3 burst, also the header word
`define FILL_BURST_W 128

// Burst address into DDR3
`define FILL_ADDR_W 23

// Data burst counter
`define FILL_COUNT_W 21

// TX words carried by one burst
`define FILL_WORDS_PER_BURST 4

// Header and checksum bursts on top of the data count
`define FILL_COUNT_EXTRA 2

// Flops in each input synchronizer
`define FILL_SYNC_STAGES 2

`endif

/* fill_hdr_pkg.sv */
// Fill header layout
package fill_hdr_pkg;

	`include "fill_defines.svh"

	// Burst address and burst count as carried in the header
	typedef logic [`FILL_ADDR_W-1:0] fill_addr_t;
	typedef logic [`FILL_COUNT_W-1:0] fill_count_t;

	// Field view of the 128-bit header, msb first
	typedef struct packed {
		logic [42:0] rsvd_hi;
		// Bits 84..64
		fill_count_t burst_count;
		logic [5:0] rsvd_mid;
		// Bits 57..35
		fill_addr_t start_addr;
		logic [34:0] rsvd_lo;
	} fill_hdr_fields_t;

	// Raw word for the compare, fields for the counters
	typedef union packed {
		logic [`FILL_BURST_W-1:0] raw;
		fill_hdr_fields_t fields;
	} fill_hdr_u;

endpackage

/* fill_header_check.sv */
// Fill header check
`timescale 1ns/100ps
`include "fill_defines.svh"

module fill_header_check (
	input  logic                      clk,
	input  logic                      rst_n,
	// One-cycle load request from the sequencer
	input  logic                      hdr_load,
	// Head of the FWFT header FIFO
	input  fill_hdr_pkg::fill_hdr_u   fill_header_fifo_out,
	input  logic [`FILL_BURST_W-1:0]  ddr3_one_burst_data,
	output logic                      fill_header_fifo_rd_en,
	output fill_hdr_pkg::fill_addr_t  start_addr,
	output fill_hdr_pkg::fill_count_t start_count,
	output logic                      hdr_match
);

	// Header as popped from the FIFO
	fill_hdr_pkg::fill_hdr_u saved_hdr;

	// Latch the FIFO head, it is already valid in FWFT mode
	always_ff @(posedge clk) begin
		if (hdr_load)
			saved_hdr <= fill_header_fifo_out;
	end

	//////////////////////////////
	// Pop strobe and compare flag
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fill_header_fifo_rd_en <= 1'b0;
			hdr_match              <= 1'b0;
		end else begin
			// Pop in the cycle the saved copy appears
			fill_header_fifo_rd_en <= hdr_load;
			// Follows whatever burst DDR3 presents
			hdr_match <= (ddr3_one_burst_data == saved_hdr.raw);
		end
	end

	// Counter start values through the field view
	assign start_addr  = saved_hdr.fields.start_addr;
	assign start_count = saved_hdr.fields.burst_count;

endmodule

/* fill_readout_chk.sv */
// Fill readout protocol checker
`timescale 1ns/100ps

module fill_readout_chk (
	input logic clk,
	input logic rst_n,
	input logic run_sm,
	input logic sm_running,
	input logic sm_done,
	input logic tx_tready,
	input logic tx_tvalid,
	input logic tx_tlast,
	input logic readout_pause,
	input logic send_csn,
	input logic send_cmd,
	input logic send_inv_cmd,
	input logic send_fill_data,
	input logic fill_header_fifo_rd_en,
	input logic ddr3_one_burst_rdy,
	input logic ddr3_rd_one_burst
);

	// Failures so far, polled from the testbench top
	int unsigned fail_count = 0;

	task automatic count_failure(input string what);
		fail_count++;
		$error("%s", what);
	endtask

	//////////////////////////////
	// Idle and start

	// Three low samples of run_sm flush the registered outputs
	a_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(!run_sm && $past(!run_sm) && $past(!run_sm, 2)) |->
		!(tx_tvalid || tx_tlast || sm_done || sm_running || ddr3_rd_one_burst ||
		fill_header_fifo_rd_en || send_csn || send_cmd || send_inv_cmd || send_fill_data))
		else count_failure("Outputs active while run_sm is low");

	a_running: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(run_sm) |=> sm_running)
		else count_failure("sm_running did not follow run_sm");

	//////////////////////////////
	// TX slots

	a_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		tx_tvalid |=> !tx_tvalid)
		else count_failure("tx_tvalid longer than one cycle");

	// Exactly one source selected with each word
	a_select: assert property (@(posedge clk) disable iff (!rst_n)
		tx_tvalid |-> $onehot({send_csn, send_cmd, send_inv_cmd, send_fill_data}))
		else count_failure("tx_tvalid without exactly one send strobe");

	// tready two samples back, pause four back through its synchronizer
	a_ready: assert property (@(posedge clk) disable iff (!rst_n)
		tx_tvalid |-> ($past(tx_tready, 2) && !$past(readout_pause, 4)))
		else count_failure("tx_tvalid sent without tready or during pause");

	a_last: assert property (@(posedge clk) disable iff (!rst_n)
		tx_tlast |-> (tx_tvalid && (send_inv_cmd || send_fill_data)))
		else count_failure("tx_tlast outside a final word");

	//////////////////////////////
	// End of command, FIFO and DDR3

	a_done: assert property (@(posedge clk) disable iff (!rst_n)
		tx_tlast |=> sm_done)
		else count_failure("sm_done missing after tx_tlast");

	a_done_only: assert property (@(posedge clk) disable iff (!rst_n)
		sm_done |-> $past(tx_tlast))
		else count_failure("sm_done without a preceding tx_tlast");

	a_pop_once: assert property (@(posedge clk) disable iff (!rst_n)
		fill_header_fifo_rd_en |=> !fill_header_fifo_rd_en)
		else count_failure("FIFO read enable longer than one cycle");

	// Request is a level until ready comes back
	a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(ddr3_rd_one_burst && !ddr3_one_burst_rdy) |=> ddr3_rd_one_burst)
		else count_failure("DDR3 request dropped before ready");

endmodule

bind fill_readout_top fill_readout_chk u_chk (
	.clk                    (clk),
	.rst_n                  (rst_n),
	.run_sm                 (run_sm),
	.sm_running             (sm_running),
	.sm_done                (sm_done),
	.tx_tready              (tx_tready),
	.tx_tvalid              (tx_tvalid),
	.tx_tlast               (tx_tlast),
	.readout_pause          (readout_pause),
	.send_csn               (send_csn),
	.send_cmd               (send_cmd),
	.send_inv_cmd           (send_inv_cmd),
	.send_fill_data         (send_fill_data),
	.fill_header_fifo_rd_en (fill_header_fifo_rd_en),
	.ddr3_one_burst_rdy     (ddr3_one_burst_rdy),
	.ddr3_rd_one_burst      (ddr3_rd_one_burst)
);

/* fill_readout_seq.sv */
// Fill readout sequencer
`timescale 1ns/100ps
`include "fill_defines.svh"

module fill_readout_seq (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       run_sm,
	input  logic                       fill_header_fifo_empty,
	input  logic                       ddr3_one_burst_rdy,
	input  logic                       readout_pause,
	input  logic                       tx_tready,
	input  logic                       hdr_match,
	input  fill_hdr_pkg::fill_addr_t   start_addr,
	input  fill_hdr_pkg::fill_count_t  start_count,
	output logic                       hdr_load,
	output logic                       ddr3_rd_one_burst,
	output logic                       sm_running,
	output logic                       sm_done,
	output logic                       slot_active,
	output logic                       slot_fire,
	output logic                       slot_last,
	output fill_hdr_pkg::fill_addr_t   ddr3_rd_burst_addr,
	output fill_ctl_pkg::fill_slot_e   slot_kind,
	output fill_ctl_pkg::fill_lane_t   slot_lane
);

	// One-hot state, st_done is the top bit
	logic [fill_ctl_pkg::st_done:0] cs;
	logic [fill_ctl_pkg::st_done:0] ns;

	// Only the st_idle bit set
	localparam logic [fill_ctl_pkg::st_done:0] cs_idle = {{fill_ctl_pkg::st_done{1'b0}}, 1'b1};

	logic [`FILL_SYNC_STAGES-1:0] rdy_sync;
	logic [`FILL_SYNC_STAGES-1:0] pause_sync;
	logic                         rdy_s;
	logic                         tx_go;
	logic                         error_found;
	logic                         burst_zero;
	fill_hdr_pkg::fill_count_t    burst_count;
	logic                         cc_slot;
	logic                         data_slot;

	//////////////////////////////
	// Input synchronizers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rdy_sync   <= '0;
			pause_sync <= '0;
		end else begin
			rdy_sync   <= {rdy_sync[`FILL_SYNC_STAGES-2:0], ddr3_one_burst_rdy};
			pause_sync <= {pause_sync[`FILL_SYNC_STAGES-2:0], readout_pause};
		end
	end

	assign rdy_s = rdy_sync[`FILL_SYNC_STAGES-1];
	// Slot may send, tready is taken as is
	assign tx_go = tx_tready & ~pause_sync[`FILL_SYNC_STAGES-1];

	//////////////////////////////
	// State register, back to idle whenever run_sm drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cs <= cs_idle;
		else if (!run_sm)
			cs <= cs_idle;
		else
			cs <= ns;
	end

	// Next state, one bit set per branch
	always_comb begin
		ns = '0;
		case (1'b1)
			cs[fill_ctl_pkg::st_idle]: ns[fill_ctl_pkg::st_chk_fifo_empty] = 1'b1;
			// Nothing queued means an error frame
			cs[fill_ctl_pkg::st_chk_fifo_empty]: begin
				if (fill_header_fifo_empty)
					ns[fill_ctl_pkg::st_error] = 1'b1;
				else
					ns[fill_ctl_pkg::st_get_fifo_hdr] = 1'b1;
			end
			cs[fill_ctl_pkg::st_error]: ns[fill_ctl_pkg::st_csn_wait] = 1'b1;
			cs[fill_ctl_pkg::st_get_fifo_hdr]: ns[fill_ctl_pkg::st_get_mem_hdr] = 1'b1;
			// Memory copy of the header
			cs[fill_ctl_pkg::st_get_mem_hdr]: begin
				if (rdy_s)
					ns[fill_ctl_pkg::st_compare_hdr] = 1'b1;
				else
					ns[fill_ctl_pkg::st_get_mem_hdr] = 1'b1;
			end
			cs[fill_ctl_pkg::st_compare_hdr]: begin
				if (hdr_match)
					ns[fill_ctl_pkg::st_csn_wait] = 1'b1;
				else
					ns[fill_ctl_pkg::st_error] = 1'b1;
			end
			// Serial number slot
			cs[fill_ctl_pkg::st_csn_wait]: begin
				if (tx_go)
					ns[fill_ctl_pkg::st_csn_send] = 1'b1;
				else
					ns[fill_ctl_pkg::st_csn_wait] = 1'b1;
			end
			cs[fill_ctl_pkg::st_csn_send]: ns[fill_ctl_pkg::st_cc_wait] = 1'b1;
			// Command or inverted command slot
			cs[fill_ctl_pkg::st_cc_wait]: begin
				if (tx_go)
					ns[fill_ctl_pkg::st_cc_send] = 1'b1;
				else
					ns[fill_ctl_pkg::st_cc_wait] = 1'b1;
			end
			// Header burst is already held, skip the fetch
			cs[fill_ctl_pkg::st_cc_send]: begin
				if (error_found)
					ns[fill_ctl_pkg::st_done] = 1'b1;
				else
					ns[fill_ctl_pkg::st_w0_wait] = 1'b1;
			end
			cs[fill_ctl_pkg::st_get_dat_burst]: begin
				if (rdy_s)
					ns[fill_ctl_pkg::st_w0_wait] = 1'b1;
				else
					ns[fill_ctl_pkg::st_get_dat_burst] = 1'b1;
			end
			// Four lanes of the current burst
			cs[fill_ctl_pkg::st_w0_wait]: begin
				if (tx_go)
					ns[fill_ctl_pkg::st_w0_send] = 1'b1;
				else
					ns[fill_ctl_pkg::st_w0_wait] = 1'b1;
			end
			cs[fill_ctl_pkg::st_w0_send]: ns[fill_ctl_pkg::st_w1_wait] = 1'b1;
			cs[fill_ctl_pkg::st_w1_wait]: begin
				if (tx_go)
					ns[fill_ctl_pkg::st_w1_send] = 1'b1;
				else
					ns[fill_ctl_pkg::st_w1_wait] = 1'b1;
			end
			cs[fill_ctl_pkg::st_w1_send]: ns[fill_ctl_pkg::st_w2_wait] = 1'b1;
			cs[fill_ctl_pkg::st_w2_wait]: begin
				if (tx_go)
					ns[fill_ctl_pkg::st_w2_send] = 1'b1;
				else
					ns[fill_ctl_pkg::st_w2_wait] = 1'b1;
			end
			cs[fill_ctl_pkg::st_w2_send]: ns[fill_ctl_pkg::st_w3_wait] = 1'b1;
			cs[fill_ctl_pkg::st_w3_wait]: begin
				if (tx_go)
					ns[fill_ctl_pkg::st_w3_send] = 1'b1;
				else
					ns[fill_ctl_pkg::st_w3_wait] = 1'b1;
			end
			// Count hit zero on the last burst's first word
			cs[fill_ctl_pkg::st_w3_send]: begin
				if (burst_zero)
					ns[fill_ctl_pkg::st_done] = 1'b1;
				else
					ns[fill_ctl_pkg::st_get_dat_burst] = 1'b1;
			end
			cs[fill_ctl_pkg::st_done]: ns[fill_ctl_pkg::st_idle] = 1'b1;
			// Illegal vector, recover through idle
			default: ns[fill_ctl_pkg::st_idle] = 1'b1;
		endcase
	end

	//////////////////////////////
	// Registered control outputs
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sm_running        <= 1'b0;
			sm_done           <= 1'b0;
			ddr3_rd_one_burst <= 1'b0;
		end else begin
			sm_running <= run_sm & ~ns[fill_ctl_pkg::st_idle];
			// One cycle behind the final tx_tlast
			sm_done    <= run_sm & cs[fill_ctl_pkg::st_done];
			// Header read waits one cycle for the address load
			ddr3_rd_one_burst <= run_sm &
				((cs[fill_ctl_pkg::st_get_mem_hdr] & ns[fill_ctl_pkg::st_get_mem_hdr]) |
				ns[fill_ctl_pkg::st_get_dat_burst]);
		end
	end

	//////////////////////////////
	// Counters and error flag
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ddr3_rd_burst_addr <= '0;
			burst_count        <= '0;
			burst_zero         <= 1'b1;
			error_found        <= 1'b0;
		end else begin
			if (cs[fill_ctl_pkg::st_get_mem_hdr]) begin
				ddr3_rd_burst_addr <= start_addr;
				burst_count        <= start_count;
			end else if (cs[fill_ctl_pkg::st_csn_send]) begin
				// Room for the header and checksum bursts
				burst_count <= burst_count + fill_hdr_pkg::fill_count_t'(`FILL_COUNT_EXTRA);
			end else if (cs[fill_ctl_pkg::st_w0_send]) begin
				burst_count        <= burst_count - 1'b1;
				ddr3_rd_burst_addr <= ddr3_rd_burst_addr + 1'b1;
			end
			burst_zero <= (burst_count == '0);
			if (cs[fill_ctl_pkg::st_idle])
				error_found <= 1'b0;
			else if (cs[fill_ctl_pkg::st_error])
				error_found <= 1'b1;
		end
	end

	// FIFO pop and header latch happen in the next cycle
	assign hdr_load = cs[fill_ctl_pkg::st_get_fifo_hdr];

	//////////////////////////////
	// Slot commands to the serializer
	assign cc_slot   = cs[fill_ctl_pkg::st_cc_wait] | cs[fill_ctl_pkg::st_cc_send];
	assign data_slot = cs[fill_ctl_pkg::st_w0_wait] | cs[fill_ctl_pkg::st_w0_send] |
		cs[fill_ctl_pkg::st_w1_wait] | cs[fill_ctl_pkg::st_w1_send] |
		cs[fill_ctl_pkg::st_w2_wait] | cs[fill_ctl_pkg::st_w2_send] |
		cs[fill_ctl_pkg::st_w3_wait] | cs[fill_ctl_pkg::st_w3_send];

	assign slot_active = cs[fill_ctl_pkg::st_csn_wait] | cs[fill_ctl_pkg::st_csn_send] |
		cc_slot | data_slot;

	// Send states last exactly one cycle
	assign slot_fire = cs[fill_ctl_pkg::st_csn_send] | cs[fill_ctl_pkg::st_cc_send] |
		cs[fill_ctl_pkg::st_w0_send] | cs[fill_ctl_pkg::st_w1_send] |
		cs[fill_ctl_pkg::st_w2_send] | cs[fill_ctl_pkg::st_w3_send];

	// Error frame ends on the command slot, success on the last lane
	assign slot_last = (cc_slot & error_found) |
		((cs[fill_ctl_pkg::st_w3_wait] | cs[fill_ctl_pkg::st_w3_send]) & burst_zero);

	always_comb begin
		slot_kind = fill_ctl_pkg::slot_serial;
		slot_lane = '0;
		if (cc_slot)
			slot_kind = error_found ? fill_ctl_pkg::slot_inv_cmd : fill_ctl_pkg::slot_cmd;
		if (data_slot)
			slot_kind = fill_ctl_pkg::slot_data;
		if (cs[fill_ctl_pkg::st_w1_wait] | cs[fill_ctl_pkg::st_w1_send])
			slot_lane = 2'd1;
		if (cs[fill_ctl_pkg::st_w2_wait] | cs[fill_ctl_pkg::st_w2_send])
			slot_lane = 2'd2;
		if (cs[fill_ctl_pkg::st_w3_wait] | cs[fill_ctl_pkg::st_w3_send])
			slot_lane = 2'd3;
	end

endmodule

/* fill_readout_top.sv */
// Fill readout engine
`timescale 1ns/100ps
`include "fill_defines.svh"

module fill_readout_top (
	input  logic                     clk,
	input  logic                     rst_n,
	// Command dispatcher
	input  logic                     run_sm,
	output logic                     sm_running,
	output logic                     sm_done,
	// TX stream
	input  logic                     tx_tready,
	output logic                     tx_tvalid,
	output logic                     tx_tlast,
	output logic [`FILL_WORD_W-1:0]  tx_data,
	input  logic                     readout_pause,
	// Source select to the command block
	output logic                     send_csn,
	output logic                     send_cmd,
	output logic                     send_inv_cmd,
	output logic                     send_fill_data,
	// Header FIFO, first-word fall-through
	input  logic                     fill_header_fifo_empty,
	input  logic [`FILL_BURST_W-1:0] fill_header_fifo_out,
	output logic                     fill_header_fifo_rd_en,
	// DDR3 reader
	input  logic                     ddr3_one_burst_rdy,
	input  logic [`FILL_BURST_W-1:0] ddr3_one_burst_data,
	output logic [`FILL_ADDR_W-1:0]  ddr3_rd_burst_addr,
	output logic                     ddr3_rd_one_burst
);

	logic                      hdr_load;
	logic                      hdr_match;
	fill_hdr_pkg::fill_addr_t  start_addr;
	fill_hdr_pkg::fill_count_t start_count;
	logic                      slot_active;
	logic                      slot_fire;
	logic                      slot_last;
	fill_ctl_pkg::fill_slot_e  slot_kind;
	fill_ctl_pkg::fill_lane_t  slot_lane;

	// Stage one, header pop and compare
	fill_header_check u_hdr_check (
		.clk                    (clk),
		.rst_n                  (rst_n),
		.hdr_load               (hdr_load),
		.fill_header_fifo_out   (fill_header_fifo_out),
		.ddr3_one_burst_data    (ddr3_one_burst_data),
		.fill_header_fifo_rd_en (fill_header_fifo_rd_en),
		.start_addr             (start_addr),
		.start_count            (start_count),
		.hdr_match              (hdr_match)
	);

	// Stage two, sequencer
	fill_readout_seq u_seq (
		.clk                    (clk),
		.rst_n                  (rst_n),
		.run_sm                 (run_sm),
		.fill_header_fifo_empty (fill_header_fifo_empty),
		.ddr3_one_burst_rdy     (ddr3_one_burst_rdy),
		.readout_pause          (readout_pause),
		.tx_tready              (tx_tready),
		.hdr_match              (hdr_match),
		.start_addr             (start_addr),
		.start_count            (start_count),
		.hdr_load               (hdr_load),
		.ddr3_rd_one_burst      (ddr3_rd_one_burst),
		.sm_running             (sm_running),
		.sm_done                (sm_done),
		.slot_active            (slot_active),
		.slot_fire              (slot_fire),
		.slot_last              (slot_last),
		.ddr3_rd_burst_addr     (ddr3_rd_burst_addr),
		.slot_kind              (slot_kind),
		.slot_lane              (slot_lane)
	);

	// Stage three, stream words
	fill_word_serializer u_ser (
		.clk                 (clk),
		.rst_n               (rst_n),
		.slot_active         (slot_active),
		.slot_fire           (slot_fire),
		.slot_last           (slot_last),
		.slot_kind           (slot_kind),
		.slot_lane           (slot_lane),
		.ddr3_one_burst_data (ddr3_one_burst_data),
		.tx_tvalid           (tx_tvalid),
		.tx_tlast            (tx_tlast),
		.send_csn            (send_csn),
		.send_cmd            (send_cmd),
		.send_inv_cmd        (send_inv_cmd),
		.send_fill_data      (send_fill_data),
		.tx_data             (tx_data)
	);

endmodule

/* fill_word_serializer.sv */
// Fill word serializer
`timescale 1ns/100ps
`include "fill_defines.svh"

module fill_word_serializer (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     slot_active,
	input  logic                     slot_fire,
	input  logic                     slot_last,
	input  fill_ctl_pkg::fill_slot_e slot_kind,
	input  fill_ctl_pkg::fill_lane_t slot_lane,
	input  logic [`FILL_BURST_W-1:0] ddr3_one_burst_data,
	output logic                     tx_tvalid,
	output logic                     tx_tlast,
	output logic                     send_csn,
	output logic                     send_cmd,
	output logic                     send_inv_cmd,
	output logic                     send_fill_data,
	output logic [`FILL_WORD_W-1:0]  tx_data
);

	// Burst split into stream words, lane 0 in the low bits
	logic [`FILL_WORDS_PER_BURST-1:0][`FILL_WORD_W-1:0] burst_words;
	logic                                              data_slot;

	assign burst_words = ddr3_one_burst_data;
	assign data_slot   = slot_active && (slot_kind == fill_ctl_pkg::slot_data);

	//////////////////////////////
	// Stream strobes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_tvalid      <= 1'b0;
			tx_tlast       <= 1'b0;
			send_csn       <= 1'b0;
			send_cmd       <= 1'b0;
			send_inv_cmd   <= 1'b0;
			send_fill_data <= 1'b0;
		end else begin
			tx_tvalid <= slot_fire;
			tx_tlast  <= slot_fire & slot_last;
			// Source select, held through wait and pulse
			send_csn       <= slot_active && (slot_kind == fill_ctl_pkg::slot_serial);
			send_cmd       <= slot_active && (slot_kind == fill_ctl_pkg::slot_cmd);
			send_inv_cmd   <= slot_active && (slot_kind == fill_ctl_pkg::slot_inv_cmd);
			send_fill_data <= data_slot;
		end
	end

	// Lane data, only meaningful while send_fill_data is high
	always_ff @(posedge clk) begin
		if (data_slot)
			tx_data <= burst_words[slot_lane];
	end

endmodule

/* tb.f */
+incdir+.
fill_hdr_pkg.sv
fill_ctl_pkg.sv
fill_header_check.sv
fill_readout_seq.sv
fill_word_serializer.sv
fill_readout_top.sv
fill_readout_chk.sv
tb_clock_gen.sv
tb_fill_readout.sv

/* tb_clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter real period_ns    = 4.0,
	parameter int  reset_cycles = 16
) (
	output logic clk,
	output logic rst_n
);

	// Free running clock
	initial begin
		clk = 1'b0;
		forever #(period_ns / 2.0) clk = ~clk;
	end

	// Reset released just after a rising edge
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#0.5;
		rst_n = 1'b1;
	end

endmodule

/* tb_fill_readout.sv */
// Fill readout testbench
`timescale 1ns/100ps
`include "fill_defines.svh"

module tb_fill_readout;

	localparam int num_cmds  = 12;
	localparam int max_count = 5;
	// Cycles one TX word may take with stalls and DDR3 latency
	localparam int stall_bound = 40;
	localparam real watchdog_ns = 1000.0 +
		num_cmds * (max_count + 3) * `FILL_WORDS_PER_BURST * stall_bound * 4.0;

	logic                     clk;
	logic                     rst_n;
	logic                     run_sm;
	logic                     tx_tready;
	logic                     readout_pause;
	logic                     fill_header_fifo_empty;
	logic [`FILL_BURST_W-1:0] fill_header_fifo_out;
	logic                     ddr3_one_burst_rdy;
	logic [`FILL_BURST_W-1:0] ddr3_one_burst_data;
	logic                     sm_running;
	logic                     sm_done;
	logic                     tx_tvalid;
	logic                     tx_tlast;
	logic [`FILL_WORD_W-1:0]  tx_data;
	logic                     send_csn;
	logic                     send_cmd;
	logic                     send_inv_cmd;
	logic                     send_fill_data;
	logic                     fill_header_fifo_rd_en;
	logic [`FILL_ADDR_W-1:0]  ddr3_rd_burst_addr;
	logic                     ddr3_rd_one_burst;

	// Current command, kind 0 empty FIFO, 1 header mismatch, 2 good fill
	int                       cur_kind;
	int                       cur_count;
	logic [`FILL_ADDR_W-1:0]  cur_addr;
	logic [`FILL_BURST_W-1:0] cur_hdr;
	logic                     stall_on;
	// Per command tallies
	int                       words;
	int                       pops;
	int                       reqs;
	// DDR3 model state
	logic                     req_q;
	int                       mem_wait;

	tb_clock_gen #(.period_ns(4.0), .reset_cycles(16)) u_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	fill_readout_top UUT (.*);

	//////////////////////////////
	// Helpers

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped on the first failure");
	endtask

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		assert (got === exp)
			else abort_run($sformatf("[FAIL] %0.1f ns %s got %0h expected %0h",
				$realtime, name, got, exp));
	endtask

	// Memory contents, every lane mixes the whole burst address
	function automatic logic [`FILL_BURST_W-1:0] mix_burst(input logic [`FILL_ADDR_W-1:0] addr);
		logic [31:0] a;
		a = {9'd0, addr};
		mix_burst = {(a * 32'h85eb_ca6b) ^ 32'hc2b2_ae35, a * 32'h27d4_eb2f,
			~a ^ 32'h1656_67b1, (a * 32'h9e37_79b9) + 32'd1};
	endfunction

	//////////////////////////////
	// DDR3 model, ready held until the request drops
	always @(posedge clk) begin
		#0.5;
		if (!ddr3_rd_one_burst) begin
			ddr3_one_burst_rdy = 1'b0;
			mem_wait = $urandom % 7;
		end else if (!ddr3_one_burst_rdy) begin
			// New request, one burst further than the last
			if (!req_q) begin
				check_value("ddr3_rd_burst_addr", ddr3_rd_burst_addr,
					cur_addr + `FILL_ADDR_W'(reqs));
				reqs++;
			end
			if (mem_wait == 0) begin
				if (ddr3_rd_burst_addr == cur_addr)
					ddr3_one_burst_data = (cur_kind == 1) ? ~cur_hdr : cur_hdr;
				else
					ddr3_one_burst_data = mix_burst(ddr3_rd_burst_addr);
				ddr3_one_burst_rdy = 1'b1;
			end else
				mem_wait--;
		end
		req_q = ddr3_rd_one_burst;
	end

	// Random back-pressure, only in commands that ask for it
	always @(posedge clk) begin
		#0.5;
		tx_tready     = !stall_on || ($urandom % 4 != 0);
		readout_pause = stall_on && ($urandom % 8 == 0);
	end

	//////////////////////////////
	// Response monitor and FIFO pop
	always @(posedge clk) begin
		int                       d;
		int                       total;
		logic [`FILL_BURST_W-1:0] burst;
		#0.5;
		if (UUT.u_chk.fail_count != 0)
			abort_run("A protocol assertion in the bound checker failed");
		total = (cur_kind == 2) ?
			2 + `FILL_WORDS_PER_BURST * (cur_count + `FILL_COUNT_EXTRA) : 2;
		if (fill_header_fifo_rd_en) begin
			pops++;
			fill_header_fifo_empty = 1'b1;
		end
		if (tx_tvalid) begin
			if (words == 0)
				check_value("send_csn", send_csn, 1);
			else if (words == 1 && cur_kind != 2)
				check_value("send_inv_cmd", send_inv_cmd, 1);
			else if (words == 1)
				check_value("send_cmd", send_cmd, 1);
			else begin
				// Header burst first, then data and checksum bursts
				d = words - 2;
				burst = (d < 4) ? cur_hdr : mix_burst(cur_addr + `FILL_ADDR_W'(d / 4));
				check_value("send_fill_data", send_fill_data, 1);
				check_value("tx_data", tx_data, burst[32 * (d % 4) +: 32]);
			end
			check_value("tx_tlast", tx_tlast, words == total - 1);
			words++;
		end
		if (sm_done) begin
			check_value("tx_tvalid pulse count", words, total);
			check_value("FIFO pop count", pops, cur_kind != 0);
			check_value("DDR3 request count", reqs,
				(cur_kind == 2) ? cur_count + `FILL_COUNT_EXTRA : cur_kind);
		end
	end

	// One read-fill command, run_sm dropped once sm_done shows
	task automatic run_command(input int kind, input logic stalls);
		logic [`FILL_BURST_W-1:0] hdr;
		@(posedge clk);
		#0.5;
		hdr       = {$urandom, $urandom, $urandom, $urandom};
		cur_addr  = `FILL_ADDR_W'($urandom % (1 << 22));
		cur_count = $urandom % (max_count + 1);
		hdr[57:35] = cur_addr;
		hdr[84:64] = `FILL_COUNT_W'(cur_count);
		cur_hdr   = hdr;
		cur_kind  = kind;
		stall_on  = stalls;
		words     = 0;
		pops      = 0;
		reqs      = 0;
		fill_header_fifo_out   = hdr;
		fill_header_fifo_empty = (kind == 0);
		run_sm = 1'b1;
		do begin
			@(posedge clk);
			#0.5;
		end while (!sm_done);
		run_sm = 1'b0;
		repeat (2 + $urandom % 4) @(posedge clk);
	endtask

	//////////////////////////////
	// Stimulus
	initial begin
		int kind;
		void'($urandom(32'hbfdc_f8b1));
		run_sm                 = 1'b0;
		tx_tready              = 1'b0;
		readout_pause          = 1'b0;
		fill_header_fifo_empty = 1'b1;
		fill_header_fifo_out   = '0;
		ddr3_one_burst_rdy     = 1'b0;
		ddr3_one_burst_data    = '0;
		cur_kind  = 0;
		cur_count = 0;
		cur_addr  = '0;
		cur_hdr   = '0;
		stall_on  = 1'b0;
		words     = 0;
		pops      = 0;
		reqs      = 0;
		req_q     = 1'b0;
		mem_wait  = 0;
		wait (rst_n);
		repeat (4) @(posedge clk);
		// Empty, mismatch and clean fill first, then a random mix under stalls
		for (int i = 0; i < num_cmds; i++) begin
			kind = (i < 3) ? i : (($urandom % 4 == 0) ? $urandom % 2 : 2);
			run_command(kind, i >= 3);
		end
		repeat (8) @(posedge clk);
		if (UUT.u_chk.fail_count == 0) begin
			$display("NO ERRORS");
			$finish;
		end else
			abort_run("A protocol assertion failed near the end of the run");
	end

	// Watchdog
	initial begin
		#(watchdog_ns);
		abort_run("Watchdog timeout, the commands did not finish in time");
	end

endmodule
